/* verilog/irq_ctl_pkg.sv */
/*
 * interrupt controller shared types
 * CSR map, bank layout and the request structs between the blocks
 */

package irq_ctl_pkg;

    typedef logic [31:0] word_t;     // CSR data word
    typedef logic [11:0] csr_addr_t; // CSR address
    typedef logic [3:0]  reg_sel_t;  // bank register index

    // ************************************************************************
    // CSR address map
    // ************************************************************************
    localparam csr_addr_t CSR_S2V = 12'h7C0; // scalar to vector request
    localparam csr_addr_t CSR_V2S = 12'h7C1; // vector to scalar flag
    localparam csr_addr_t CSR_TID = 12'h7C2; // target warp and thread
    localparam csr_addr_t CSR_IPC = 12'h7C3; // interrupted pc
    localparam csr_addr_t CSR_IRQ = 12'h7C4; // handler pc
    localparam csr_addr_t CSR_ERR = 12'h7C5;
    localparam csr_addr_t CSR_RHA = 12'h7C6; // return handler address
    localparam csr_addr_t CSR_RAV = 12'h7C7; // scheduler return pc

    localparam reg_sel_t SEL_S2V  = 4'd0;
    localparam reg_sel_t SEL_V2S  = 4'd1;
    localparam reg_sel_t SEL_TID  = 4'd2;
    localparam reg_sel_t SEL_IPC  = 4'd3;
    localparam reg_sel_t SEL_IRQ  = 4'd4;
    localparam reg_sel_t SEL_ERR  = 4'd5;
    localparam reg_sel_t SEL_RHA  = 4'd6;
    localparam reg_sel_t SEL_RAV  = 4'd7;
    localparam reg_sel_t SEL_NONE = 4'd15; // unmapped address

    typedef enum logic [2:0] {
        IRQC_IDLE        = 3'd0,
        IRQC_WAIT        = 3'd1,
        IRQC_PC_SWAP     = 3'd2,
        IRQC_WAIT_ISR    = 3'd3,
        IRQC_REVERT_WARP = 3'd4
    } irq_state_e;

    // ************************************************************************
    // bank and request structs
    // ************************************************************************
    typedef struct packed {
        word_t s2v;
        word_t v2s;
        word_t tid;
        word_t ipc;
        word_t irq;
        word_t err;
        word_t rha;
        word_t rav;
        word_t tmask;
        word_t wmask;
    } irq_regs_t;

    typedef struct packed {
        logic     valid;
        reg_sel_t sel;
        word_t    data;
    } csr_wr_t;

    typedef struct packed {
        logic  set_fault;   // ERR=1, V2S=1
        logic  clear_flags; // ERR=0, V2S=0
        logic  raise_v2s;
        logic  capture;     // load TMASK, WMASK, IPC
        word_t cap_tmask;
        word_t cap_wmask;
        word_t cap_pc;
    } fsm_upd_t;

    typedef struct packed {
        logic  pipeline_drained;
        logic  thread_found;
        logic  isr_done;
        word_t current_pc;
        word_t current_tmask; // zero extended
        word_t current_wmask; // zero extended
    } ttu_status_t;

endpackage

/* verilog/irq_csr_port.sv */
/*
 * CSR port of the interrupt controller
 * address decode, write lane pick from the thread mask and read return
 */

`timescale 1ns/10ps

module irq_csr_port #(
    parameter int NUM_THREADS = 4
) (
    input  logic                                     read_enable,
    input  logic                                     write_enable,
    input  irq_ctl_pkg::csr_addr_t                   read_addr,
    input  irq_ctl_pkg::csr_addr_t                   write_addr,
    input  logic [NUM_THREADS-1:0]                   write_mask,
    input  irq_ctl_pkg::word_t [NUM_THREADS-1:0]     write_data,
    input  irq_ctl_pkg::irq_regs_t                   regs,
    output irq_ctl_pkg::word_t [NUM_THREADS-1:0]     read_data,
    output irq_ctl_pkg::csr_wr_t                     wr
);

    localparam int LANE_W = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1;

    irq_ctl_pkg::csr_addr_t addr;
    irq_ctl_pkg::reg_sel_t  sel;
    irq_ctl_pkg::word_t     rd_word;
    logic [LANE_W-1:0]      wr_lane;

    assign addr = write_enable ? write_addr : read_addr; // write address wins

    always_comb
    begin
        case (addr)
            irq_ctl_pkg::CSR_S2V: sel = irq_ctl_pkg::SEL_S2V;
            irq_ctl_pkg::CSR_V2S: sel = irq_ctl_pkg::SEL_V2S;
            irq_ctl_pkg::CSR_TID: sel = irq_ctl_pkg::SEL_TID;
            irq_ctl_pkg::CSR_IPC: sel = irq_ctl_pkg::SEL_IPC;
            irq_ctl_pkg::CSR_IRQ: sel = irq_ctl_pkg::SEL_IRQ;
            irq_ctl_pkg::CSR_ERR: sel = irq_ctl_pkg::SEL_ERR;
            irq_ctl_pkg::CSR_RHA: sel = irq_ctl_pkg::SEL_RHA;
            irq_ctl_pkg::CSR_RAV: sel = irq_ctl_pkg::SEL_RAV;
            default:              sel = irq_ctl_pkg::SEL_NONE;
        endcase
    end

    // lowest set mask bit picks the lane, lane 0 if none
    always_comb
    begin
        wr_lane = '0;
        for (int i = NUM_THREADS - 1; i >= 0; i--)
        begin
            if (write_mask[i])
                wr_lane = LANE_W'(i);
        end
    end

    assign wr.valid = write_enable && (sel != irq_ctl_pkg::SEL_NONE);
    assign wr.sel   = sel;
    assign wr.data  = write_data[wr_lane];

    always_comb
    begin
        case (sel)
            irq_ctl_pkg::SEL_S2V: rd_word = regs.s2v;
            irq_ctl_pkg::SEL_V2S: rd_word = regs.v2s;
            irq_ctl_pkg::SEL_TID: rd_word = regs.tid;
            irq_ctl_pkg::SEL_IPC: rd_word = regs.ipc;
            irq_ctl_pkg::SEL_IRQ: rd_word = regs.irq;
            irq_ctl_pkg::SEL_ERR: rd_word = regs.err;
            irq_ctl_pkg::SEL_RHA: rd_word = regs.rha;
            irq_ctl_pkg::SEL_RAV: rd_word = regs.rav;
            default:              rd_word = '0;
        endcase
    end

    // same value on every lane
    assign read_data = read_enable ? {NUM_THREADS{rd_word}} : '0;

endmodule

/* verilog/irq_reg_arbiter.sv */
/*
 * control register bank of the interrupt controller
 * merges port writes, FSM updates and the execute commit by priority
 */

`timescale 1ns/10ps

module irq_reg_arbiter (
    input  logic                   clk,
    input  logic                   reset,
    input  irq_ctl_pkg::csr_wr_t   simt_wr,
    input  irq_ctl_pkg::csr_wr_t   scalar_wr,
    input  irq_ctl_pkg::fsm_upd_t  upd,
    input  logic                   commit_ret_pc,
    input  irq_ctl_pkg::word_t     ret_pc,
    output irq_ctl_pkg::irq_regs_t regs
);

    irq_ctl_pkg::irq_regs_t bank;
    irq_ctl_pkg::irq_regs_t next_bank;

    // one CSR write applied on top of a bank image
    function automatic irq_ctl_pkg::irq_regs_t apply_wr(
        input irq_ctl_pkg::irq_regs_t cur,
        input irq_ctl_pkg::csr_wr_t   w
    );
        irq_ctl_pkg::irq_regs_t res;
        res = cur;
        if (w.valid)
        begin
            case (w.sel)
                irq_ctl_pkg::SEL_S2V: res.s2v = w.data;
                irq_ctl_pkg::SEL_V2S: res.v2s = w.data;
                irq_ctl_pkg::SEL_TID: res.tid = w.data;
                irq_ctl_pkg::SEL_IPC: res.ipc = w.data;
                irq_ctl_pkg::SEL_IRQ: res.irq = w.data;
                irq_ctl_pkg::SEL_ERR: res.err = w.data;
                irq_ctl_pkg::SEL_RHA: res.rha = w.data;
                irq_ctl_pkg::SEL_RAV: res.rav = w.data;
                default:
                begin
                    res = cur;
                end
            endcase
        end
        return res;
    endfunction

    // ************************************************************************
    // next bank, lowest priority first
    // ************************************************************************
    always_comb
    begin
        next_bank = bank;
        next_bank = apply_wr(next_bank, simt_wr);
        next_bank = apply_wr(next_bank, scalar_wr); // scalar beats simt

        // transfer FSM updates
        if (upd.raise_v2s)
            next_bank.v2s = 32'd1; // scalar may load the thread
        if (upd.clear_flags)
        begin
            next_bank.v2s = '0;
            next_bank.err = '0;
        end
        if (upd.set_fault)
        begin
            next_bank.err = 32'd1; // bad thread request
            next_bank.v2s = 32'd1;
        end
        if (upd.capture)
        begin
            next_bank.tmask = upd.cap_tmask;
            next_bank.wmask = upd.cap_wmask;
            next_bank.ipc   = upd.cap_pc;
        end

        // execute stage has the last word on RAV
        if (commit_ret_pc)
            next_bank.rav = ret_pc;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            bank <= '0;
        end
        else
        begin
            bank <= next_bank;
        end
    end

    assign regs = bank;

endmodule

/* verilog/irq_transfer_fsm.sv */
/*
 * thread transfer state machine
 * drives bank updates and the load outputs of the thread-transfer unit
 */

`timescale 1ns/10ps

module irq_transfer_fsm #(
    parameter int NUM_THREADS = 4,
    parameter int NUM_WARPS   = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  irq_ctl_pkg::irq_regs_t    regs,
    input  irq_ctl_pkg::ttu_status_t  ttu_status,
    output irq_ctl_pkg::fsm_upd_t     upd,
    output irq_ctl_pkg::irq_state_e   state,
    output logic [((NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1)-1:0]     wid,
    output logic [((NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1)-1:0] tid,
    output logic [NUM_THREADS-1:0]    load_tmask,
    output logic [NUM_WARPS-1:0]      load_wmask,
    output irq_ctl_pkg::word_t        load_pc,
    output irq_ctl_pkg::word_t        ret_handler_addr
);

    localparam int NT_W = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1;
    localparam int NW_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1;

    irq_ctl_pkg::irq_state_e next_state;
    logic                    s2v_zero;
    logic                    s2v_req;
    logic                    drained;
    logic                    found;

    assign s2v_zero = (regs.s2v == '0);
    assign s2v_req  = (regs.s2v == 32'd1);
    assign drained  = ttu_status.pipeline_drained;
    assign found    = ttu_status.thread_found;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= irq_ctl_pkg::IRQC_IDLE;
        else
            state <= next_state;
    end

    // ************************************************************************
    // next state
    // ************************************************************************
    always_comb
    begin
        next_state = state;
        case (state)
            irq_ctl_pkg::IRQC_IDLE:
                if (s2v_req) next_state = irq_ctl_pkg::IRQC_WAIT;
            irq_ctl_pkg::IRQC_WAIT:
            begin
                if (drained)
                    next_state = found ? irq_ctl_pkg::IRQC_PC_SWAP : irq_ctl_pkg::IRQC_IDLE;
            end
            irq_ctl_pkg::IRQC_PC_SWAP:
                next_state = irq_ctl_pkg::IRQC_WAIT_ISR; // single cycle
            irq_ctl_pkg::IRQC_WAIT_ISR:
                if (ttu_status.isr_done) next_state = irq_ctl_pkg::IRQC_REVERT_WARP;
            irq_ctl_pkg::IRQC_REVERT_WARP:
                if (s2v_zero) next_state = irq_ctl_pkg::IRQC_IDLE; // scalar done loading
            default:
                next_state = irq_ctl_pkg::IRQC_IDLE;
        endcase
    end

    // bank update requests
    always_comb
    begin
        upd           = '0;
        upd.cap_tmask = ttu_status.current_tmask;
        upd.cap_wmask = ttu_status.current_wmask;
        upd.cap_pc    = ttu_status.current_pc;
        case (state)
            irq_ctl_pkg::IRQC_IDLE:
                upd.clear_flags = s2v_zero; // scalar acked the error
            irq_ctl_pkg::IRQC_WAIT:
            begin
                upd.set_fault = drained && !found;
                upd.capture   = drained && found;
            end
            irq_ctl_pkg::IRQC_REVERT_WARP:
            begin
                upd.clear_flags = s2v_zero;
                upd.raise_v2s   = !s2v_zero;
            end
            default:
            begin
                upd.set_fault = 1'b0;
            end
        endcase
    end

    // to thread transfer unit
    assign wid              = regs.tid[NT_W+NW_W-1:NT_W];
    assign tid              = regs.tid[NT_W-1:0];
    assign load_tmask       = regs.tmask[NUM_THREADS-1:0];
    assign load_wmask       = regs.wmask[NUM_WARPS-1:0];
    assign load_pc          = (state == irq_ctl_pkg::IRQC_PC_SWAP) ? regs.irq : regs.ipc;
    assign ret_handler_addr = regs.rha; // to execute stage

endmodule

/* verilog/irq_ctl_top.sv */
/*
 * interrupt controller top, SIMT to scalar thread transfer
 * two CSR ports, the register bank and the transfer FSM
 */

`timescale 1ns/10ps

module irq_ctl_top #(
    parameter int NUM_THREADS = 4,
    parameter int NUM_WARPS   = 4
) (
    input  logic                                     clk,
    input  logic                                     reset,
    // SIMT CSR port
    input  logic                                     simt_read_enable,
    input  logic                                     simt_write_enable,
    input  irq_ctl_pkg::csr_addr_t                   simt_read_addr,
    input  irq_ctl_pkg::csr_addr_t                   simt_write_addr,
    input  logic [NUM_THREADS-1:0]                   simt_write_mask,
    input  irq_ctl_pkg::word_t [NUM_THREADS-1:0]     simt_write_data,
    output irq_ctl_pkg::word_t [NUM_THREADS-1:0]     simt_read_data,
    // scalar CSR port
    input  logic                                     scalar_read_enable,
    input  logic                                     scalar_write_enable,
    input  irq_ctl_pkg::csr_addr_t                   scalar_read_addr,
    input  irq_ctl_pkg::csr_addr_t                   scalar_write_addr,
    input  logic [NUM_THREADS-1:0]                   scalar_write_mask,
    input  irq_ctl_pkg::word_t [NUM_THREADS-1:0]     scalar_write_data,
    output irq_ctl_pkg::word_t [NUM_THREADS-1:0]     scalar_read_data,
    // thread transfer unit
    input  irq_ctl_pkg::ttu_status_t                 ttu_status,
    output irq_ctl_pkg::irq_state_e                  state,
    output logic [((NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1)-1:0]     wid,
    output logic [((NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1)-1:0] tid,
    output logic [NUM_THREADS-1:0]                   load_tmask,
    output logic [NUM_WARPS-1:0]                     load_wmask,
    output irq_ctl_pkg::word_t                       load_pc,
    // execute stage
    input  logic                                     commit_ret_pc,
    input  irq_ctl_pkg::word_t                       ret_pc,
    output irq_ctl_pkg::word_t                       ret_handler_addr
);

    irq_ctl_pkg::irq_regs_t regs;
    irq_ctl_pkg::csr_wr_t   simt_wr;
    irq_ctl_pkg::csr_wr_t   scalar_wr;
    irq_ctl_pkg::fsm_upd_t  upd;

    irq_csr_port #(.NUM_THREADS(NUM_THREADS)) simt_port_i (
        .read_enable  (simt_read_enable),
        .write_enable (simt_write_enable),
        .read_addr    (simt_read_addr),
        .write_addr   (simt_write_addr),
        .write_mask   (simt_write_mask),
        .write_data   (simt_write_data),
        .regs         (regs),
        .read_data    (simt_read_data),
        .wr           (simt_wr)
    );

    irq_csr_port #(.NUM_THREADS(NUM_THREADS)) scalar_port_i (
        .read_enable  (scalar_read_enable),
        .write_enable (scalar_write_enable),
        .read_addr    (scalar_read_addr),
        .write_addr   (scalar_write_addr),
        .write_mask   (scalar_write_mask),
        .write_data   (scalar_write_data),
        .regs         (regs),
        .read_data    (scalar_read_data),
        .wr           (scalar_wr)
    );

    irq_transfer_fsm #(
        .NUM_THREADS (NUM_THREADS),
        .NUM_WARPS   (NUM_WARPS)
    ) fsm_i (
        .clk              (clk),
        .reset            (reset),
        .regs             (regs),
        .ttu_status       (ttu_status),
        .upd              (upd),
        .state            (state),
        .wid              (wid),
        .tid              (tid),
        .load_tmask       (load_tmask),
        .load_wmask       (load_wmask),
        .load_pc          (load_pc),
        .ret_handler_addr (ret_handler_addr)
    );

    irq_reg_arbiter arbiter_i (
        .clk           (clk),
        .reset         (reset),
        .simt_wr       (simt_wr),
        .scalar_wr     (scalar_wr),
        .upd           (upd),
        .commit_ret_pc (commit_ret_pc),
        .ret_pc        (ret_pc),
        .regs          (regs)
    );

endmodule

/* tb/irq_ctl_checker.sv */
/*
 * interrupt controller assertions, bound into the top level
 */

`timescale 1ns/10ps

module irq_ctl_checker #(
    parameter int NUM_THREADS = 4
) (
    input logic                                 clk,
    input logic                                 reset,
    input irq_ctl_pkg::irq_state_e              state,
    input logic                                 simt_read_enable,
    input irq_ctl_pkg::word_t [NUM_THREADS-1:0] simt_read_data,
    input logic                                 scalar_read_enable,
    input irq_ctl_pkg::word_t [NUM_THREADS-1:0] scalar_read_data
);

    int failures = 0; // read by the testbench at the end

    // pc swap is a single cycle step
    a_swap_then_isr: assert property (@(posedge clk) disable iff (reset)
        state == irq_ctl_pkg::IRQC_PC_SWAP |=> state == irq_ctl_pkg::IRQC_WAIT_ISR)
        else
        begin
            $error("PC_SWAP was not followed by WAIT_ISR");
            failures++;
        end

    a_reset_idle: assert property (@(posedge clk)
        reset |=> state == irq_ctl_pkg::IRQC_IDLE)
        else
        begin
            $error("state not IDLE in the cycle after reset");
            failures++;
        end

    a_simt_rd_zero: assert property (@(posedge clk)
        !simt_read_enable |-> simt_read_data == '0)
        else
        begin
            $error("SIMT read data nonzero with read_enable low");
            failures++;
        end

    a_scalar_rd_zero: assert property (@(posedge clk)
        !scalar_read_enable |-> scalar_read_data == '0)
        else
        begin
            $error("scalar read data nonzero with read_enable low");
            failures++;
        end

endmodule

bind irq_ctl_top irq_ctl_checker #(.NUM_THREADS(NUM_THREADS)) checker_i (
    .clk                (clk),
    .reset              (reset),
    .state              (state),
    .simt_read_enable   (simt_read_enable),
    .simt_read_data     (simt_read_data),
    .scalar_read_enable (scalar_read_enable),
    .scalar_read_data   (scalar_read_data)
);

/* tb/irq_ctl_tb.sv */
/*
 * testbench of the interrupt controller
 * directed tests over both CSR ports
 */

`timescale 1ns/10ps

module irq_ctl_tb;

    localparam int NT             = 4;
    localparam int NW             = 4;
    localparam int CLK_PERIOD     = 40;
    localparam int TEST_CYCLES    = 160; // rough length of all tests
    localparam int STATE_WAIT_MAX = 20;

    typedef irq_ctl_pkg::word_t [NT-1:0] lanes_t;

    logic clk;
    logic reset;
    logic simt_read_enable, simt_write_enable, scalar_read_enable, scalar_write_enable;
    irq_ctl_pkg::csr_addr_t simt_read_addr, simt_write_addr;
    irq_ctl_pkg::csr_addr_t scalar_read_addr, scalar_write_addr;
    logic [NT-1:0] simt_write_mask, scalar_write_mask;
    lanes_t simt_write_data, scalar_write_data, simt_read_data, scalar_read_data;
    irq_ctl_pkg::ttu_status_t ttu_status;
    irq_ctl_pkg::irq_state_e state;
    logic [$clog2(NW)-1:0] wid;
    logic [$clog2(NT)-1:0] tid;
    logic [NT-1:0] load_tmask;
    logic [NW-1:0] load_wmask;
    irq_ctl_pkg::word_t load_pc, ret_pc, ret_handler_addr;
    logic commit_ret_pc;
    logic [31:0] seed = 32'h734360c6;
    int errors = 0;
    int checks = 0;
    int assert_failures = 0;

    irq_ctl_top #(.NUM_THREADS(NT), .NUM_WARPS(NW)) dut_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic irq_ctl_pkg::word_t lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic lanes_t rand_lanes();
        lanes_t v;
        for (int i = 0; i < NT; i++)
            v[i] = lcg_next();
        return v;
    endfunction

    // lowest set mask bit or lane 0 for an empty mask
    function automatic irq_ctl_pkg::word_t expected_lane(input logic [NT-1:0] mask,
                                                         input lanes_t data);
        irq_ctl_pkg::word_t val;
        bit hit;
        val = data[0];
        hit = 1'b0;
        for (int i = 0; i < NT; i++)
        begin
            if (mask[i] && !hit)
            begin
                val = data[i];
                hit = 1'b1;
            end
        end
        return val;
    endfunction

    // ************************************************************************
    // drive and check helpers
    // ************************************************************************
    task automatic check_word(input string name, input irq_ctl_pkg::word_t exp,
                              input irq_ctl_pkg::word_t act);
        checks++;
        assert (act === exp)
        else
        begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_state(input irq_ctl_pkg::irq_state_e exp, input string name);
        checks++;
        assert (state === exp)
        else
        begin
            errors++;
            $display("CHECK FAILED %s: expected %s, actual %s", name, exp.name(), state.name());
        end
    endtask

    task automatic wait_state(input irq_ctl_pkg::irq_state_e exp, input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (state !== exp && n < STATE_WAIT_MAX)
        begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (state === exp)
        else
        begin
            errors++;
            $display("%s: state never reached %s within %0d cycles", name, exp.name(),
                     STATE_WAIT_MAX);
        end
    endtask

    task automatic drive_write(input bit scalar, input irq_ctl_pkg::csr_addr_t addr,
                               input logic [NT-1:0] mask, input lanes_t data);
        if (scalar)
        begin
            scalar_write_enable <= 1'b1;
            scalar_write_addr   <= addr;
            scalar_write_mask   <= mask;
            scalar_write_data   <= data;
        end
        else
        begin
            simt_write_enable <= 1'b1;
            simt_write_addr   <= addr;
            simt_write_mask   <= mask;
            simt_write_data   <= data;
        end
    endtask

    task automatic end_writes();
        simt_write_enable   <= 1'b0;
        scalar_write_enable <= 1'b0;
        commit_ret_pc       <= 1'b0;
    endtask

    task automatic csr_write(input bit scalar, input irq_ctl_pkg::csr_addr_t addr,
                             input logic [NT-1:0] mask, input lanes_t data);
        @(posedge clk);
        drive_write(scalar, addr, mask, data);
        @(posedge clk);
        end_writes();
    endtask

    // every lane must carry the register value
    task automatic read_check(input bit scalar, input irq_ctl_pkg::csr_addr_t addr,
                              input irq_ctl_pkg::word_t exp, input string name);
        @(posedge clk);
        if (scalar)
        begin
            scalar_read_enable <= 1'b1;
            scalar_read_addr   <= addr;
        end
        else
        begin
            simt_read_enable <= 1'b1;
            simt_read_addr   <= addr;
        end
        @(negedge clk);
        for (int i = 0; i < NT; i++)
            check_word(name, exp, scalar ? scalar_read_data[i] : simt_read_data[i]);
        @(posedge clk);
        if (scalar)
            scalar_read_enable <= 1'b0; // address stays mapped
        else
            simt_read_enable <= 1'b0;
        @(negedge clk);
    endtask

    // ************************************************************************
    // directed tests
    // ************************************************************************
    task automatic test_reset_values();
        for (int i = 0; i < 8; i++)
        begin
            read_check(1'b0, irq_ctl_pkg::CSR_S2V + 12'(i), '0, "reset simt");
            read_check(1'b1, irq_ctl_pkg::CSR_S2V + 12'(i), '0, "reset scalar");
        end
        check_state(irq_ctl_pkg::IRQC_IDLE, "reset state");
        check_word("reset load_pc", '0, load_pc);
        check_word("reset loads", '0, {load_tmask, load_wmask, wid, tid});
    endtask

    task automatic test_lane_select();
        logic [NT-1:0] masks [4];
        irq_ctl_pkg::csr_addr_t addrs [3];
        lanes_t data;
        masks = '{4'b0000, 4'b0100, 4'b1010, 4'b1000};
        addrs = '{irq_ctl_pkg::CSR_IRQ, irq_ctl_pkg::CSR_RHA, irq_ctl_pkg::CSR_TID};
        for (int i = 0; i < 6; i++)
        begin
            data = rand_lanes();
            csr_write(1'b0, addrs[i % 3], masks[i % 4], data);
            read_check(1'b1, addrs[i % 3], expected_lane(masks[i % 4], data), "lane select");
            if (addrs[i % 3] == irq_ctl_pkg::CSR_RHA)
                check_word("lane select rha out", expected_lane(masks[i % 4], data),
                           ret_handler_addr);
        end
    endtask

    task automatic test_priority();
        lanes_t simt_val;
        lanes_t scalar_val;
        irq_ctl_pkg::word_t commit_val;
        simt_val   = rand_lanes();
        scalar_val = rand_lanes();
        @(posedge clk);
        drive_write(1'b0, irq_ctl_pkg::CSR_IRQ, 4'b0001, simt_val);
        drive_write(1'b1, irq_ctl_pkg::CSR_IRQ, 4'b0001, scalar_val);
        @(posedge clk);
        end_writes();
        read_check(1'b0, irq_ctl_pkg::CSR_IRQ, scalar_val[0], "priority irq");
        commit_val = lcg_next();
        @(posedge clk);
        drive_write(1'b0, irq_ctl_pkg::CSR_RAV, 4'b0010, rand_lanes());
        drive_write(1'b1, irq_ctl_pkg::CSR_RAV, 4'b0010, rand_lanes());
        commit_ret_pc <= 1'b1; // execute commit beats both ports
        ret_pc        <= commit_val;
        @(posedge clk);
        end_writes();
        read_check(1'b1, irq_ctl_pkg::CSR_RAV, commit_val, "priority rav");
    endtask

    task automatic test_transfer();
        lanes_t irq_val;
        irq_ctl_pkg::word_t pc;
        irq_val = rand_lanes();
        pc      = lcg_next();
        csr_write(1'b1, irq_ctl_pkg::CSR_TID, '0, {NT{32'h0000_000B}}); // warp 2 and thread 3
        csr_write(1'b0, irq_ctl_pkg::CSR_IRQ, 4'b0001, irq_val);
        @(negedge clk);
        check_word("transfer wid", 32'd2, 32'(wid));
        check_word("transfer tid", 32'd3, 32'(tid));
        csr_write(1'b1, irq_ctl_pkg::CSR_S2V, '0, {NT{32'd1}});
        wait_state(irq_ctl_pkg::IRQC_WAIT, "transfer request");
        @(posedge clk);
        ttu_status <= '{pipeline_drained: 1'b1, thread_found: 1'b1, isr_done: 1'b0,
                        current_pc: pc, current_tmask: 32'h5, current_wmask: 32'h9};
        @(posedge clk);
        ttu_status.pipeline_drained <= 1'b0;
        ttu_status.thread_found     <= 1'b0;
        @(negedge clk);
        check_state(irq_ctl_pkg::IRQC_PC_SWAP, "transfer swap");
        check_word("transfer load_pc irq", irq_val[0], load_pc);
        check_word("transfer load_tmask", 32'h5, 32'(load_tmask));
        check_word("transfer load_wmask", 32'h9, 32'(load_wmask));
        @(negedge clk);
        check_state(irq_ctl_pkg::IRQC_WAIT_ISR, "transfer isr");
        check_word("transfer load_pc ipc", pc, load_pc);
        read_check(1'b1, irq_ctl_pkg::CSR_IPC, pc, "transfer ipc");
        @(posedge clk);
        ttu_status.isr_done <= 1'b1;
        @(posedge clk);
        ttu_status.isr_done <= 1'b0;
        wait_state(irq_ctl_pkg::IRQC_REVERT_WARP, "transfer revert");
        read_check(1'b1, irq_ctl_pkg::CSR_V2S, 32'd1, "transfer v2s set");
        csr_write(1'b1, irq_ctl_pkg::CSR_S2V, '0, '0);
        wait_state(irq_ctl_pkg::IRQC_IDLE, "transfer return");
        read_check(1'b1, irq_ctl_pkg::CSR_V2S, '0, "transfer v2s clear");
        read_check(1'b0, irq_ctl_pkg::CSR_ERR, '0, "transfer err clear");
    endtask

    task automatic pulse_drained_no_thread();
        @(posedge clk);
        ttu_status.pipeline_drained <= 1'b1;
        @(posedge clk);
        ttu_status.pipeline_drained <= 1'b0;
    endtask

    task automatic test_bad_request();
        csr_write(1'b1, irq_ctl_pkg::CSR_S2V, '0, {NT{32'd1}});
        wait_state(irq_ctl_pkg::IRQC_WAIT, "bad request");
        pulse_drained_no_thread();
        @(negedge clk);
        check_state(irq_ctl_pkg::IRQC_IDLE, "bad request state");
        read_check(1'b1, irq_ctl_pkg::CSR_ERR, 32'd1, "bad request err");
        read_check(1'b0, irq_ctl_pkg::CSR_V2S, 32'd1, "bad request v2s");
        // S2V still set so the FSM rearmed and waits for another drain
        csr_write(1'b1, irq_ctl_pkg::CSR_S2V, '0, '0);
        pulse_drained_no_thread();
        wait_state(irq_ctl_pkg::IRQC_IDLE, "bad request ack");
        read_check(1'b1, irq_ctl_pkg::CSR_ERR, '0, "bad request err clear");
        read_check(1'b0, irq_ctl_pkg::CSR_V2S, '0, "bad request v2s clear");
        check_state(irq_ctl_pkg::IRQC_IDLE, "bad request idle");
    endtask

    initial
    begin
        reset <= 1'b1;
        simt_read_enable <= 1'b0;
        scalar_read_enable <= 1'b0;
        simt_read_addr <= '0;
        scalar_read_addr <= '0;
        simt_write_addr <= '0;
        scalar_write_addr <= '0;
        simt_write_mask <= '0;
        scalar_write_mask <= '0;
        simt_write_data <= '0;
        scalar_write_data <= '0;
        ttu_status <= '0;
        ret_pc <= '0;
        end_writes();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        test_reset_values();
        test_lane_select();
        test_priority();
        test_transfer();
        test_bad_request();
        assert_failures = dut_i.checker_i.failures;
        $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 assert_failures);
        if (errors == 0 && assert_failures == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        #(CLK_PERIOD * TEST_CYCLES * 4);
        $display("watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* list.f */
verilog/irq_ctl_pkg.sv
verilog/irq_csr_port.sv
verilog/irq_reg_arbiter.sv
verilog/irq_transfer_fsm.sv
verilog/irq_ctl_top.sv
tb/irq_ctl_checker.sv
tb/irq_ctl_tb.sv
